// ==== flist.f ====
+incdir+.
cnt_pkg.sv
cnt_if.sv
cnt_ram.sv
cnt_decode.sv
cnt_execute.sv
cnt_result.sv
cnt_table_top.sv
tb_cnt_table.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the counter table testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
  --top-module tb_cnt_table -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== tb_cnt_table.sv ====
// Directed testbench for the counter table top level
// A reference model predicts every response; a monitor checks data, flag and latency
`timescale 1ns/1ps
`default_nettype none

module tb_cnt_table;

  localparam int CMD_TOTAL = 329;  // Commands issued over all tests
  localparam int LATENCY   = 4;    // Drive cycle to response cycle

  logic               clkb = 1'b0;
  logic               rstb;
  logic               cmd_valid;
  logic [2:0]         cmd_op;
  cnt_pkg::cnt_addr_t cmd_addr;
  cnt_pkg::cnt_data_t cmd_data;
  logic               rsp_valid;
  logic               rsp_err;
  cnt_pkg::cnt_data_t rsp_data;

  cnt_pkg::cnt_data_t model [64];  // Expected table contents
  cnt_pkg::cnt_data_t exp_data [$];
  logic               exp_err [$];
  int                 exp_cycle [$];
  string              exp_name [$];

  int    cycle      = 0;  // Rising edges seen
  int    data_errs  = 0;
  int    flag_errs  = 0;
  int    other_errs = 0;
  string cur_test   = "reset";

  cnt_table_top dut_i (
    .clkb      (clkb),
    .rstb      (rstb),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .rsp_valid (rsp_valid),
    .rsp_err   (rsp_err),
    .rsp_data  (rsp_data)
  );

  always #50 clkb = ~clkb;  // 100 ns period

  always @(posedge clkb) cycle <= cycle + 1;

  task automatic check_data(input string name, input cnt_pkg::cnt_data_t exp,
                            input cnt_pkg::cnt_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("FAILED %s: rsp_data expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("FAILED %s: rsp_err expected %b, actual %b", name, exp, act);
    end
  endtask

  // Entry value after a legal command, per opcode rules
  function automatic cnt_pkg::cnt_data_t next_value(input logic [2:0] op,
                                                    input cnt_pkg::cnt_data_t old_v,
                                                    input cnt_pkg::cnt_data_t arg);
    case (op)
      cnt_pkg::OP_WRITE: return arg;
      cnt_pkg::OP_ADD:   return old_v + arg;  // Wraps
      cnt_pkg::OP_RDCLR: return '0;
      cnt_pkg::OP_MAX:   return (arg > old_v) ? arg : old_v;
      default:           return old_v;
    endcase
  endfunction

  // Drives one command on the falling edge and records what must come back
  task automatic issue_cmd(input logic [2:0] op, input cnt_pkg::cnt_addr_t addr,
                           input cnt_pkg::cnt_data_t data);
    logic               bad;
    cnt_pkg::cnt_data_t old_v;
    @(negedge clkb);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_data  = data;
    bad   = (op > 3'd4);
    old_v = bad ? cnt_pkg::cnt_data_t'(0) : model[addr];
    exp_data.push_back(old_v);
    exp_err.push_back(bad);
    exp_cycle.push_back(cycle);
    exp_name.push_back(cur_test);
    if (!bad) model[addr] = next_value(op, model[addr], data);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clkb);
      cmd_valid = 1'b0;
    end
  endtask

  // Waits for every outstanding response, bounded
  task automatic drain();
    int n;
    n = 0;
    idle(1);
    while (exp_data.size() != 0 && n < 20) begin
      @(posedge clkb);
      n++;
    end
    if (exp_data.size() != 0) begin
      other_errs++;
      $display("Missing responses in %s: %0d commands never answered",
               cur_test, exp_data.size());
      exp_data.delete();
      exp_err.delete();
      exp_cycle.delete();
      exp_name.delete();
    end
  endtask

  // Response monitor, samples on the falling edge where outputs are stable
  always @(negedge clkb) begin
    int    lat;
    string name;
    if (rsp_valid === 1'b1) begin
      if (exp_data.size() == 0) begin
        other_errs++;
        $display("Unexpected response with no command outstanding at cycle %0d", cycle);
      end else begin
        name = exp_name.pop_front();
        lat  = cycle - exp_cycle.pop_front();
        check_data(name, exp_data.pop_front(), rsp_data);
        check_err(name, exp_err.pop_front(), rsp_err);
        if (lat != LATENCY) begin
          other_errs++;
          $display("FAILED %s: latency expected %0d, actual %0d", name, LATENCY, lat);
        end
      end
    end
  end

  task automatic test_write_read();
    cur_test = "write_read";
    issue_cmd(cnt_pkg::OP_READ, 6'd5, 32'h0);  // Fresh entry reads zero
    idle(3);
    issue_cmd(cnt_pkg::OP_WRITE, 6'd5, 32'hdeadbeef);
    idle(3);
    issue_cmd(cnt_pkg::OP_READ, 6'd5, 32'h0);
    idle(3);
    issue_cmd(cnt_pkg::OP_WRITE, 6'd5, 32'h12345678);  // Returns previous value
    idle(2);
    issue_cmd(cnt_pkg::OP_READ, 6'd5, 32'h0);
    drain();
  endtask

  task automatic test_add_chain();
    cur_test = "add_chain";
    issue_cmd(cnt_pkg::OP_WRITE, 6'd9, 32'd100);
    for (int i = 1; i <= 10; i++) begin
      issue_cmd(cnt_pkg::OP_ADD, 6'd9, cnt_pkg::cnt_data_t'(i * 7));  // Same addr every cycle
    end
    issue_cmd(cnt_pkg::OP_READ, 6'd9, 32'h0);
    drain();
  endtask

  task automatic test_rdclr_max();
    cur_test = "rdclr_max";
    issue_cmd(cnt_pkg::OP_WRITE, 6'd20, 32'h500);
    issue_cmd(cnt_pkg::OP_RDCLR, 6'd20, 32'h0);
    issue_cmd(cnt_pkg::OP_READ, 6'd20, 32'h0);
    issue_cmd(cnt_pkg::OP_WRITE, 6'd20, 32'h80);
    issue_cmd(cnt_pkg::OP_MAX, 6'd20, 32'h300);  // Above stored value
    issue_cmd(cnt_pkg::OP_MAX, 6'd20, 32'h100);  // Below it
    issue_cmd(cnt_pkg::OP_READ, 6'd20, 32'h0);
    drain();
  endtask

  task automatic test_illegal();
    cur_test = "illegal";
    issue_cmd(cnt_pkg::OP_WRITE, 6'd33, 32'habc);
    idle(1);
    for (int op = 5; op <= 7; op++) begin
      issue_cmd(3'(op), 6'd33, 32'hffff0000);
    end
    issue_cmd(cnt_pkg::OP_READ, 6'd33, 32'h0);  // Entry must still hold abc
    drain();
  endtask

  task automatic test_random();
    cur_test = "random";
    for (int i = 0; i < 300; i++) begin
      issue_cmd(3'($urandom % 8), cnt_pkg::cnt_addr_t'(8 + $urandom % 4), $urandom);
    end
    drain();
  endtask

  // Watchdog
  initial begin
    repeat (CMD_TOTAL * 10 + 200) @(posedge clkb);
    $display("Timeout: run did not finish within %0d cycles", CMD_TOTAL * 10 + 200);
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hff4e50f7));
    for (int i = 0; i < 64; i++) model[i] = '0;  // RAM powers up as zero
    rstb      = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = 3'd0;
    cmd_addr  = '0;
    cmd_data  = '0;
    repeat (8) @(posedge clkb);
    @(negedge clkb);
    if (rsp_valid !== 1'b0 || rsp_err !== 1'b0) begin
      other_errs++;
      $display("Response strobes not low during reset");
    end
    rstb = 1'b0;
    idle(2);
    test_write_read();
    test_add_chain();
    test_rdclr_max();
    test_illegal();
    test_random();
    idle(4);
    $display("Errors: data %0d, flag %0d, other %0d", data_errs, flag_errs, other_errs);
    if (data_errs + flag_errs + other_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cnt_table_top.sv ====
// Top level of the counter table with plain command and response ports
// Response comes four clocks after the command, one command per clock
`timescale 1ns/1ps
`default_nettype none

`include "cnt_params.svh"

module cnt_table_top (
  input  wire logic               clkb,
  input  wire logic               rstb,       // Synchronous, active high
  input  wire logic               cmd_valid,  // Command strobe
  input  wire logic [2:0]         cmd_op,     // Raw opcode, 5 to 7 illegal
  input  wire cnt_pkg::cnt_addr_t cmd_addr,   // Counter index
  input  wire cnt_pkg::cnt_data_t cmd_data,   // Operand
  output logic                    rsp_valid,  // Response strobe
  output logic                    rsp_err,    // Illegal opcode flag
  output cnt_pkg::cnt_data_t      rsp_data    // Entry value before the command
);

  // RAM read port
  logic               enb;
  logic               regceb;
  cnt_pkg::cnt_addr_t addrb;
  cnt_pkg::cnt_data_t doutb;

  // RAM write port
  logic               wea;
  cnt_pkg::cnt_addr_t addra;
  cnt_pkg::cnt_data_t dina;

  cnt_req_if  req_if ();   // Decode to execute
  cnt_pipe_if pipe_if ();  // Execute to result

  cnt_decode decode_i (
    .clkb      (clkb),
    .rstb      (rstb),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_data  (cmd_data),
    .req       (req_if.source)
  );

  cnt_execute execute_i (
    .clkb   (clkb),
    .rstb   (rstb),
    .req    (req_if.sink),
    .enb    (enb),
    .addrb  (addrb),
    .regceb (regceb),
    .pipe   (pipe_if.source)
  );

  cnt_ram #(
    .RAM_WIDTH (`CNT_WIDTH),
    .RAM_DEPTH (`CNT_DEPTH)
  ) ram_i (
    .clkb   (clkb),
    .rstb   (rstb),
    .wea    (wea),
    .addra  (addra),
    .dina   (dina),
    .enb    (enb),
    .addrb  (addrb),
    .regceb (regceb),
    .doutb  (doutb)
  );

  cnt_result result_i (
    .clkb      (clkb),
    .rstb      (rstb),
    .pipe      (pipe_if.sink),
    .doutb     (doutb),
    .wea       (wea),
    .addra     (addra),
    .dina      (dina),
    .rsp_valid (rsp_valid),
    .rsp_err   (rsp_err),
    .rsp_data  (rsp_data)
  );

endmodule

`default_nettype wire

// ==== cnt_result.sv ====
// Update and response stage of the counter table
// Picks the old value, computes the new one per opcode and writes it back
// A two-entry write history covers RAM reads that missed the last two writes
`timescale 1ns/1ps
`default_nettype none

module cnt_result (
  input  wire logic               clkb,
  input  wire logic               rstb,
  cnt_pipe_if.sink                pipe,
  input  wire cnt_pkg::cnt_data_t doutb,      // RAM read data
  output logic                    wea,        // RAM write enable
  output cnt_pkg::cnt_addr_t      addra,      // RAM write address
  output cnt_pkg::cnt_data_t      dina,       // RAM write data
  output logic                    rsp_valid,  // Response strobe
  output logic                    rsp_err,    // Illegal opcode
  output cnt_pkg::cnt_data_t      rsp_data    // Old entry value
);

  cnt_pkg::cnt_data_t old_val;    // Entry value before this command
  cnt_pkg::cnt_data_t new_val;    // Entry value after this command
  logic               do_write;   // Command modifies the entry

  // Write history, index 0 is the newest
  logic [1:0]         hist_vld;
  cnt_pkg::cnt_addr_t hist_addr [2];
  cnt_pkg::cnt_data_t hist_data [2];

  // Newest matching write wins over the RAM data
  always_comb begin
    if (hist_vld[0] && (hist_addr[0] == pipe.addr)) begin
      old_val = hist_data[0];
    end else if (hist_vld[1] && (hist_addr[1] == pipe.addr)) begin
      old_val = hist_data[1];
    end else begin
      old_val = doutb;
    end
  end

  // Per-opcode update
  always_comb begin
    case (pipe.op)
      cnt_pkg::OP_WRITE: new_val = pipe.operand;
      cnt_pkg::OP_ADD:   new_val = old_val + pipe.operand;  // Wraps at full width
      cnt_pkg::OP_RDCLR: new_val = '0;
      cnt_pkg::OP_MAX:   new_val = (pipe.operand > old_val) ? pipe.operand : old_val;
      default:           new_val = old_val;                 // OP_READ
    endcase
  end

  assign do_write = pipe.valid & ~pipe.illegal & (pipe.op != cnt_pkg::OP_READ);

  // Write lands in the RAM on the same edge as the response register
  assign wea   = do_write;
  assign addra = pipe.addr;
  assign dina  = new_val;

  // Response strobes
  always_ff @(posedge clkb) begin
    if (rstb) begin
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
    end else begin
      rsp_valid <= pipe.valid;
      rsp_err   <= pipe.valid & pipe.illegal;
    end
  end

  // Response data, zero for an illegal opcode
  always_ff @(posedge clkb) begin
    if (pipe.valid) begin
      rsp_data <= pipe.illegal ? '0 : old_val;
    end
  end

  // History shifts every cycle, so a slot ages out after two cycles
  always_ff @(posedge clkb) begin
    if (rstb) begin
      hist_vld <= '0;
    end else begin
      hist_vld <= {hist_vld[0], do_write};
    end
  end

  always_ff @(posedge clkb) begin
    hist_addr[1] <= hist_addr[0];
    hist_data[1] <= hist_data[0];
    hist_addr[0] <= pipe.addr;
    hist_data[0] <= new_val;
  end

endmodule

`default_nettype wire

// ==== cnt_execute.sv ====
// Read issue stage of the counter table
// Starts the RAM read and delays the command by the two-cycle RAM latency
`timescale 1ns/1ps
`default_nettype none

module cnt_execute (
  input  wire logic          clkb,
  input  wire logic          rstb,
  cnt_req_if.sink            req,
  output logic               enb,     // RAM read enable
  output cnt_pkg::cnt_addr_t addrb,   // RAM read address
  output logic               regceb,  // RAM output register enable
  cnt_pipe_if.source         pipe
);

  // First delay stage, in step with the RAM read register
  logic               s1_valid;
  cnt_pkg::cnt_op_e   s1_op;
  logic               s1_illegal;
  cnt_pkg::cnt_addr_t s1_addr;
  cnt_pkg::cnt_data_t s1_operand;

  // Illegal commands never touch the RAM
  assign enb   = req.valid & ~req.illegal;
  assign addrb = req.addr;

  // Control bits of both stages
  always_ff @(posedge clkb) begin
    if (rstb) begin
      s1_valid   <= 1'b0;
      regceb     <= 1'b0;
      pipe.valid <= 1'b0;
    end else begin
      s1_valid   <= req.valid;
      regceb     <= enb;       // Output register loads one cycle after the read
      pipe.valid <= s1_valid;  // Lines up with doutb
    end
  end

  // Payload delay line
  always_ff @(posedge clkb) begin
    s1_op        <= req.op;
    s1_illegal   <= req.illegal;
    s1_addr      <= req.addr;
    s1_operand   <= req.operand;
    pipe.op      <= s1_op;
    pipe.illegal <= s1_illegal;
    pipe.addr    <= s1_addr;
    pipe.operand <= s1_operand;
  end

endmodule

`default_nettype wire

// ==== cnt_decode.sv ====
// First pipeline stage of the counter table
// Registers each strobed command and turns the raw opcode into the enum
`timescale 1ns/1ps
`default_nettype none

module cnt_decode (
  input  wire logic               clkb,
  input  wire logic               rstb,
  input  wire logic               cmd_valid,  // Command strobe
  input  wire logic [2:0]         cmd_op,     // Raw opcode
  input  wire cnt_pkg::cnt_addr_t cmd_addr,
  input  wire cnt_pkg::cnt_data_t cmd_data,
  cnt_req_if.source               req
);

  logic             op_bad;  // Raw code beyond the last defined opcode
  cnt_pkg::cnt_op_e op_dec;  // Code mapped onto the enum

  assign op_bad = (cmd_op > cnt_pkg::OP_MAX);

  // Illegal codes map to a harmless read so op always holds a defined value
  always_comb begin
    if (op_bad) begin
      op_dec = cnt_pkg::OP_READ;
    end else begin
      op_dec = cnt_pkg::cnt_op_e'(cmd_op);
    end
  end

  // Strobe register
  always_ff @(posedge clkb) begin
    if (rstb) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= cmd_valid;
    end
  end

  // Command fields, loaded only with a command
  always_ff @(posedge clkb) begin
    if (cmd_valid) begin
      req.op      <= op_dec;
      req.illegal <= op_bad;
      req.addr    <= cmd_addr;
      req.operand <= cmd_data;
    end
  end

endmodule

`default_nettype wire

// ==== cnt_ram.sv ====
// Simple dual-port block RAM, one write port and one read port on clkb
// Read path has a data register and an output register, so reads take two cycles
`timescale 1ns/1ps
`default_nettype none

module cnt_ram #(
  parameter int RAM_WIDTH = 32,  // Data width
  parameter int RAM_DEPTH = 64   // Number of words
) (
  input  wire logic                         clkb,
  input  wire logic                         rstb,    // Clears output register only
  input  wire logic                         wea,     // Write enable
  input  wire logic [$clog2(RAM_DEPTH)-1:0] addra,   // Write address
  input  wire logic [RAM_WIDTH-1:0]         dina,    // Write data
  input  wire logic                         enb,     // Read enable
  input  wire logic [$clog2(RAM_DEPTH)-1:0] addrb,   // Read address
  input  wire logic                         regceb,  // Output register enable
  output logic      [RAM_WIDTH-1:0]         doutb    // Registered read data
);

  logic [RAM_WIDTH-1:0] mem [RAM_DEPTH];  // Storage array
  logic [RAM_WIDTH-1:0] ram_data;         // First read stage

  // Contents start at zero, as the device does after configuration
  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Write port
  always_ff @(posedge clkb) begin
    if (wea) begin
      mem[addra] <= dina;
    end
  end

  // Read port, old data on a same-edge write
  always_ff @(posedge clkb) begin
    if (enb) begin
      ram_data <= mem[addrb];
    end
  end

  // Output register
  always_ff @(posedge clkb) begin
    if (rstb) begin
      doutb <= '0;
    end else if (regceb) begin
      doutb <= ram_data;
    end
  end

endmodule

`default_nettype wire

// ==== cnt_if.sv ====
// Pipeline bundles of the counter table
// cnt_req_if runs decode to execute, cnt_pipe_if runs execute to result
`timescale 1ns/1ps
`default_nettype none

// Decoded command, one cycle strobe per command
interface cnt_req_if;
  logic                valid;    // Command present this cycle
  cnt_pkg::cnt_op_e    op;       // Decoded opcode
  logic                illegal;  // Raw opcode was out of range
  cnt_pkg::cnt_addr_t  addr;     // Entry index
  cnt_pkg::cnt_data_t  operand;  // Command data

  modport source (output valid, op, illegal, addr, operand);
  modport sink   (input  valid, op, illegal, addr, operand);
endinterface

// Command aligned with the RAM read data
interface cnt_pipe_if;
  logic                valid;    // RAM output for this command is on doutb
  cnt_pkg::cnt_op_e    op;
  logic                illegal;
  cnt_pkg::cnt_addr_t  addr;
  cnt_pkg::cnt_data_t  operand;

  modport source (output valid, op, illegal, addr, operand);
  modport sink   (input  valid, op, illegal, addr, operand);
endinterface

`default_nettype wire

// ==== cnt_pkg.sv ====
// Shared types for the counter table: opcode enum, counter value and address
// Referenced by scoped name from the RTL and the testbench
`default_nettype none

`include "cnt_params.svh"

package cnt_pkg;

  // Command opcodes, codes 5 to 7 are illegal
  typedef enum logic [2:0] {
    OP_READ  = 3'd0,  // Return value only
    OP_WRITE = 3'd1,  // Overwrite with operand
    OP_ADD   = 3'd2,  // Wrapping add of operand
    OP_RDCLR = 3'd3,  // Return value, then zero the entry
    OP_MAX   = 3'd4   // Keep unsigned max of entry and operand
  } cnt_op_e;

  // One counter value
  typedef logic [`CNT_WIDTH-1:0] cnt_data_t;

  // Table index
  typedef logic [`CNT_ADDR_W-1:0] cnt_addr_t;

endpackage

`default_nettype wire

// ==== cnt_params.svh ====
// Sizing macros for the counter table, shared by the package and the top level
// Include wherever the counter width or table depth is needed
`ifndef CNT_PARAMS_SVH
`define CNT_PARAMS_SVH

// Bits per counter entry
`define CNT_WIDTH  32

// Number of counters in the table
`define CNT_DEPTH  64

// Entry address width, log2 of CNT_DEPTH
`define CNT_ADDR_W 6

`endif
